//--- run.sh
#!/bin/sh
# Compiles the expansion stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module iexpandTb -Mdir "$BUILD" -o iexpandSim -f sources.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$BUILD/iexpandSim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation finished without failures"
exit 0

//--- sim/iexpandTb.sv
// Testbench for the instruction-expansion stage
// Directed parcels and windows, stall cases and a random mix, checked by assertions
`timescale 1ns/1ps

module iexpandTb;
	import iexpPkg::*;

	logic clk;
	logic rstN;
	logic stall;
	fetchBundle fetchIn;
	expandResult result;

	instrWord expInstr;	// Hand-derived expansion of a directed parcel
	logic expKnown;
	logic took;
	logic [31:0] pc;
	logic [31:0] randLow;
	logic [31:0] randHigh;
	logic [31:0] randCtl;
	integer seed;
	int errors;
	int cycles;
	int cycleLimit;
	int testsRun;
	int testStart;
	int stallCycles;

	iexpandTop iexpandTop_inst
	(
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.fetchIn(fetchIn),
		.result(result)
	);

	always #5 clk = ~clk;

	assign took = fetchIn.valid && !stall;

	function automatic logic [2:0] refLength(input instrWord w);
		if (!w[7])
			return 3'd2;
		return (w[7:6] == sizeWide48) ? 3'd6 : 3'd4;
	endfunction

	function automatic instrWord refWide(input instrWord w);
		return (w[7:6] == sizeWide32) ? {16'h0000, w[31:0]} : w;	// Upper parcel dropped
	endfunction

	function automatic logic refIllegal(input instrWord w);
		return w[7] && !legalMajorOps[w[5:0]];
	endfunction

	function automatic int totalErrors();
		return errors + iexpandTop_inst.iexpandTop_sva_inst.failCount;
	endfunction

	task automatic reportError(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		$display("test %s finished with %0d errors", name, totalErrors() - testStart);
		testStart = totalErrors();
	endtask

	// Fetch holds the bundle through the stall, then it is taken on one edge
	task automatic sendBundle(input logic v, input instrWord w, input instrWord exp,
		input logic known, input int holdCycles);
		fetchIn.valid = v;
		fetchIn.window = w;
		fetchIn.pc = pc;
		expInstr = exp;
		expKnown = known;
		stall = (holdCycles != 0);
		repeat (holdCycles)
		begin
			@(posedge clk);
			#1;
		end
		stall = 1'b0;
		@(posedge clk);
		#1;
		if (v)
			pc = pc + 32'(refLength(w));
	endtask

	// ====================
	// Reference checks one cycle after a take
	checkTake: assert property (@(posedge clk) disable iff (!rstN)
		took |=> result.valid && result.pc == $past(fetchIn.pc)
			&& result.length == refLength($past(fetchIn.window))
			&& result.compressed == !$past(fetchIn.window[7]))
		else reportError("valid, pc, length or class differs from the taken bundle");

	checkWide: assert property (@(posedge clk) disable iff (!rstN)
		took && fetchIn.window[7] |=> result.instr == refWide($past(fetchIn.window))
			&& result.illegal == refIllegal($past(fetchIn.window)))
		else reportError("wide instruction or illegal flag wrong");

	checkShape: assert property (@(posedge clk) disable iff (!rstN)
		took && !fetchIn.window[7] |=> result.instr[7:6] == 2'b10
			&& result.instr[47:32] == 16'h0000 && !result.illegal)
		else reportError("compressed expansion has wrong size bits or upper parcel");

	checkDirected: assert property (@(posedge clk) disable iff (!rstN)
		took && expKnown |=> result.instr == $past(expInstr))
		else reportError("compressed expansion differs from expected form");

	checkIdle: assert property (@(posedge clk) disable iff (!rstN)
		!fetchIn.valid && !stall |=> !result.valid)
		else reportError("valid not cleared after an idle cycle");

	// ====================
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		stall = 1'b0;
		fetchIn = '0;
		expInstr = '0;
		expKnown = 1'b0;
		pc = 32'h0000_1000;
		seed = 32'ha21;
		errors = 0;
		cycles = 0;
		testsRun = 0;
		testStart = 0;
		cycleLimit = 4 * (6 + 24 + 5 + 12 + 200 * 4 + 1);	// Worst case random stalls

		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		finishTest("reset");

		// Upper 32 bits of each window are junk the expander must ignore
		sendBundle(1'b1, {32'hDEADBEEF, 16'h0E25},
			{16'h0, 14'h3FFD, 5'd5, 5'd5, 2'b10, opAddi}, 1'b1, 0);	// ADDI r5, -3
		sendBundle(1'b1, {32'hDEADBEEF, 16'h0F1F},
			{16'h0, 14'h3FF0, regSp, regSp, 2'b10, opAddi}, 1'b1, 0);	// SP adjust -2 words
		sendBundle(1'b1, {32'hDEADBEEF, 16'h1427},
			{16'h0, 14'd9, 5'd7, 5'd0, 2'b10, opOri}, 1'b1, 0);	// LDI r7, 9
		sendBundle(1'b1, {32'hDEADBEEF, 16'h1220},
			{16'h0, 8'h00, 3'd1, 5'd0, 8'h25, 2'b10, opBrk}, 1'b1, 0);	// SYS cause 5
		sendBundle(1'b1, {32'hDEADBEEF, 16'h2100},
			{16'h0, 14'd16, regLink, regSp, 2'b10, opRet}, 1'b1, 0);
		sendBundle(1'b1, {32'hDEADBEEF, 16'h2F27},
			{16'h0, 14'h3FFF, 5'd7, 5'd7, 2'b10, opAndi}, 1'b1, 0);	// ANDI r7, -1
		sendBundle(1'b1, {32'hDEADBEEF, 16'h3129},
			{16'h0, fnShiftI, 3'd0, 5'd3, 5'd9, 5'd9, 2'b10, opR2}, 1'b1, 0);	// SHLI r9, 3
		sendBundle(1'b1, {32'hDEADBEEF, 16'h420B},
			{16'h0, fnShiftI, 3'd1, 5'd5, 5'd11, 5'd11, 2'b10, opR2}, 1'b1, 0);	// SHRI
		sendBundle(1'b1, {32'hDEADBEEF, 16'h4F17},
			{16'h0, fnShiftI, 3'd3, 5'd30, 5'd20, 5'd20, 2'b10, opR2}, 1'b1, 0);	// ASRI
		sendBundle(1'b1, {32'hDEADBEEF, 16'h4826},
			{16'h0, 14'h3FF0, 5'd19, 5'd19, 2'b10, opOri}, 1'b1, 0);	// Mapped ORI
		sendBundle(1'b1, {32'hDEADBEEF, 16'h423A},
			{16'h0, fnSub, 3'b011, 5'd18, 5'd4, 5'd4, 2'b10, opR2}, 1'b1, 0);	// Mapped regs
		sendBundle(1'b1, {32'hDEADBEEF, 16'h4C38},
			{16'h0, fnXor, 3'b011, 5'd3, 5'd1, 5'd1, 2'b10, opR2}, 1'b1, 0);
		sendBundle(1'b1, {32'hDEADBEEF, 16'h702B},
			{16'h0, 9'd10, 5'd0, 2'b11, 8'h00, 2'b10, opBcc}, 1'b1, 0);	// Branch always
		sendBundle(1'b1, {32'hDEADBEEF, 16'h8706},
			{16'h0, 9'd3, 5'd0, 2'b10, 3'b000, 5'd6, 2'b10, opBcc}, 1'b1, 0);	// BEQ r6
		sendBundle(1'b1, {32'hDEADBEEF, 16'hEE24},
			{16'h0, 9'h1F7, 5'd0, 2'b01, 3'b001, 5'd4, 2'b10, opBcc}, 1'b1, 0);	// BNE r4
		sendBundle(1'b1, {32'hDEADBEEF, 16'h0652},
			{16'h0, fnMov, 3'd7, 5'd0, 5'd12, 5'd18, 2'b10, opR2}, 1'b1, 0);	// MOV
		sendBundle(1'b1, {32'hDEADBEEF, 16'h106A},
			{16'h0, fnAdd, 3'b011, 5'd1, 5'd10, 5'd10, 2'b10, opR2}, 1'b1, 0);	// ADD
		sendBundle(1'b1, {32'hDEADBEEF, 16'h5169},
			{16'h0, 14'd28, 5'd9, regSp, 2'b10, opLx}, 1'b1, 0);	// Word load off SP
		sendBundle(1'b1, {32'hDEADBEEF, 16'hA66C},
			{16'h0, 9'd1, 5'd12, 5'b10110, regFp, 2'b10, opSx}, 1'b1, 0);	// Half store off FP
		sendBundle(1'b1, {32'hDEADBEEF, 16'hD671},
			{16'h0, 14'd52, 5'd18, 5'd3, 2'b10, opLx}, 1'b1, 0);	// Word load off r3
		sendBundle(1'b1, {32'hDEADBEEF, 16'hEB5C},
			{16'h0, 9'h1FF, 5'd19, 5'b01110, 5'd12, 2'b10, opSx}, 1'b1, 0);	// Half store off r12
		sendBundle(1'b1, {32'hDEADBEEF, 16'h2E63},
			{16'h0, 14'd0, 5'd29, 5'd3, 2'b10, opJal}, 1'b1, 0);	// JALR
		sendBundle(1'b1, {32'hDEADBEEF, 16'h3040},
			{16'h0, 24'd0, 2'b10, opNop}, 1'b1, 0);	// Unassigned encoding
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		finishTest("compressed expansion");

		sendBundle(1'b1, {16'hBEEF, 32'h1234_5684}, '0, 1'b0, 0);	// 32-bit ADDI
		sendBundle(1'b1, {16'hBEEF, 32'h0000_00BF}, '0, 1'b0, 0);	// Opcode 3F not legal
		sendBundle(1'b1, 48'h1357_9BDF_00C2, '0, 1'b0, 0);	// 48-bit R2
		sendBundle(1'b1, 48'hFFFF_0000_00C1, '0, 1'b0, 0);
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		finishTest("wide formats");

		sendBundle(1'b1, {16'h0000, 32'h1234_5684}, '0, 1'b0, 3);
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		sendBundle(1'b1, {32'hCAFE0000, 16'h0E25},
			{16'h0, 14'h3FFD, 5'd5, 5'd5, 2'b10, opAddi}, 1'b1, 1);
		sendBundle(1'b1, 48'h1357_9BDF_00C2, '0, 1'b0, 2);
		sendBundle(1'b1, {32'h0, 16'h1427}, {16'h0, 14'd9, 5'd7, 5'd0, 2'b10, opOri}, 1'b1, 0);
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		finishTest("timing and stall");

		for (int i = 0; i < 200; i++)
		begin
			randLow = $random(seed);
			randHigh = $random(seed);
			randCtl = $random(seed);
			stallCycles = (randCtl[6:4] == 3'd0) ? int'(randCtl[8:7]) : 0;
			sendBundle(randCtl[3:0] != 4'd0, {randHigh[15:0], randLow}, '0, 1'b0, stallCycles);
		end
		sendBundle(1'b0, '0, '0, 1'b0, 0);
		finishTest("random mix");

		$display("%0d tests run, %0d errors", testsRun, totalErrors());
		if (totalErrors() == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sim/iexpandTop_sva.sv
// Protocol assertions for the expansion stage, bound into its top level
// Covers reset, stall hold, the valid strobe and the length and flag fields
`timescale 1ns/1ps

module iexpandTop_sva
(
	input logic clk,
	input logic rstN,
	input logic stall,
	input iexpPkg::fetchBundle fetchIn,
	input iexpPkg::expandResult result
);

	int failCount = 0;	// Read back by the testbench

	// ====================
	resetClears: assert property (@(posedge clk)
		!rstN |=> !result.valid && !result.illegal)
		else
		begin
			$error("result valid or illegal still set after a reset edge");
			failCount++;
		end

	stallHolds: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(result))
		else
		begin
			$error("result changed while stall was high");
			failCount++;
		end

	validFollowsTake: assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) && !$past(stall) |-> result.valid == $past(fetchIn.valid))
		else
		begin
			$error("result valid does not follow the fetch strobe");
			failCount++;
		end

	illegalOnlyWide: assert property (@(posedge clk) disable iff (!rstN)
		result.illegal |-> result.valid && !result.compressed)
		else
		begin
			$error("illegal set on an idle or compressed result");
			failCount++;
		end

	lengthByClass: assert property (@(posedge clk) disable iff (!rstN)
		result.valid |-> (result.compressed ? result.length == 3'd2 :
			(result.length == 3'd4 || result.length == 3'd6)))
		else
		begin
			$error("length does not match the size class");
			failCount++;
		end

endmodule

bind iexpandTop iexpandTop_sva iexpandTop_sva_inst
(
	.clk(clk),
	.rstN(rstN),
	.stall(stall),
	.fetchIn(fetchIn),
	.result(result)
);

//--- sources.f
src/iexpPkg.sv
src/compressedExpander.sv
src/wideFormatter.sv
src/expandSelect.sv
src/iexpandTop.sv
sim/iexpandTop_sva.sv
sim/iexpandTb.sv

//--- src/compressedExpander.sv
// Expands a 16-bit compressed parcel into the 48-bit canonical form
// Purely combinational, output always carries size class 10
`timescale 1ns/1ps

module compressedExpander
(
	input  logic [15:0] cinstr,
	output iexpPkg::instrWord expand
);
	import iexpPkg::*;

	logic [4:0] rd;		// Full register field
	logic [4:0] imm5;	// Common 5-bit immediate
	logic [4:0] rpLow;	// Mapped register from bits 2:0
	logic [4:0] rpMid;	// Mapped register from bits 9:8 and 5
	logic [4:0] rpSrc;	// Mapped source of register-register ops
	logic [4:0] frameBase;

	assign rd = cinstr[4:0];
	assign imm5 = {cinstr[11:8], cinstr[5]};
	assign rpLow = cRegMap[cinstr[2:0]];
	assign rpMid = cRegMap[{cinstr[9:8], cinstr[5]}];
	assign rpSrc = cRegMap[{cinstr[9:8], cinstr[3]}];
	assign frameBase = cinstr[13] ? regFp : regSp;

	always_comb
	begin
		expand = '0;		// Upper parcel and unused fields stay zero
		expand[7:6] = 2'b10;
		casez ({cinstr[15:12], cinstr[6]})
		// ====================
		// Immediate group
		5'b00000:
		begin
			if (rd == regSp)
				expand[31:18] = {{6{cinstr[11]}}, imm5, 3'b000};	// Stack adjust in words
			else
				expand[31:18] = {{9{cinstr[11]}}, imm5};
			expand[17:13] = rd;
			expand[12:8] = rd;
			expand[5:0] = opAddi;
		end
		5'b00010:
		begin
			if (rd == 5'd0)
			begin
				expand[23:21] = 3'd1;		// System call class
				expand[15:8] = {3'd1, imm5};	// Cause code
				expand[5:0] = opBrk;
			end
			else
			begin
				expand[31:18] = {{9{cinstr[11]}}, imm5};	// LDI as ORI from r0
				expand[17:13] = rd;
				expand[5:0] = opOri;
			end
		end
		5'b00100:
		begin
			if (rd == 5'd0)
			begin
				expand[31:18] = {6'd0, imm5, 3'b000};	// Stack release on return
				expand[17:13] = regLink;
				expand[12:8] = regSp;
				expand[5:0] = opRet;
			end
			else
			begin
				expand[31:18] = {{9{cinstr[11]}}, imm5};
				expand[17:13] = rd;
				expand[12:8] = rd;
				expand[5:0] = opAndi;
			end
		end
		5'b00110:
		begin
			expand[31:26] = fnShiftI;	// SHLI
			expand[22:18] = imm5;
			expand[17:13] = rd;
			expand[12:8] = rd;
			expand[5:0] = opR2;
		end
		// ====================
		// Mapped-register group
		5'b01000:
		begin
			expand[17:13] = rpLow;
			expand[12:8] = rpLow;
			if (cinstr[5] == 1'b0)
			begin
				expand[31:26] = fnShiftI;
				expand[25:23] = cinstr[4] ? 3'd3 : 3'd1;	// ASR or SHR
				expand[22:18] = {cinstr[11:8], cinstr[3]};
				expand[5:0] = opR2;
			end
			else if (cinstr[4] == 1'b0)
			begin
				expand[31:18] = {{9{cinstr[11]}}, cinstr[11:8], cinstr[3]};
				expand[5:0] = opOri;
			end
			else
			begin
				case (cinstr[11:10])
				2'd0:
					expand[31:26] = fnSub;
				2'd1:
					expand[31:26] = fnAnd;
				2'd2:
					expand[31:26] = fnOr;
				default:
					expand[31:26] = fnXor;
				endcase
				expand[25:23] = 3'b011;		// Word size
				expand[22:18] = rpSrc;
				expand[5:0] = opR2;
			end
		end
		// ====================
		// Flow control and moves
		5'b01110:
		begin
			expand[31:23] = {cinstr[11], cinstr[11:8], cinstr[5:2]};	// Always taken
			expand[17:16] = cinstr[1:0];
			expand[5:0] = opBcc;
		end
		5'b1???0:
		begin
			expand[31:23] = {{4{cinstr[13]}}, cinstr[13:9]};
			expand[17:16] = {cinstr[8], cinstr[5]};
			expand[15:13] = {2'b00, cinstr[14]};	// BEQ or BNE against r0
			expand[12:8] = rd;
			expand[5:0] = opBcc;
		end
		5'b00001:
		begin
			expand[31:26] = fnMov;
			expand[25:23] = 3'd7;
			expand[17:13] = imm5;
			expand[12:8] = rd;
			expand[5:0] = opR2;
		end
		5'b00011:
		begin
			expand[31:26] = fnAdd;
			expand[25:23] = 3'b011;
			expand[22:18] = imm5;
			expand[17:13] = rd;
			expand[12:8] = rd;
			expand[5:0] = opR2;
		end
		5'b00101:
		begin
			expand[17:13] = imm5;	// JALR link register
			expand[12:8] = rd;
			expand[5:0] = opJal;
		end
		// ====================
		// Loads and stores, size tag in the displacement low bits
		5'b01??1:
		begin
			if (cinstr[12])
				expand[31:18] = {{6{cinstr[11]}}, imm5, 3'd4};
			else
				expand[31:18] = {{7{cinstr[11]}}, imm5, 2'd2};
			expand[17:13] = rd;
			expand[12:8] = frameBase;
			expand[5:0] = opLx;
		end
		5'b10??1:
		begin
			if (cinstr[12])
			begin
				expand[31:23] = {{6{cinstr[11]}}, cinstr[11:9]};
				expand[17:13] = {cinstr[8], cinstr[5], 3'd4};
			end
			else
			begin
				expand[31:23] = {{7{cinstr[11]}}, cinstr[11:10]};
				expand[17:13] = {cinstr[9:8], cinstr[5], 2'd2};
			end
			expand[22:18] = rd;
			expand[12:8] = frameBase;
			expand[5:0] = opSx;
		end
		5'b11??1:
		begin
			expand[12:8] = rpLow;
			if (cinstr[13] == 1'b0)
			begin
				if (cinstr[12])
					expand[31:18] = {{7{cinstr[11]}}, cinstr[11:10], cinstr[4:3], 3'd4};
				else
					expand[31:18] = {{8{cinstr[11]}}, cinstr[11:10], cinstr[4:3], 2'd2};
				expand[17:13] = rpMid;
				expand[5:0] = opLx;
			end
			else
			begin
				if (cinstr[12])
				begin
					expand[31:23] = {{7{cinstr[11]}}, cinstr[11:10]};
					expand[17:13] = {cinstr[4:3], 3'd4};
				end
				else
				begin
					expand[31:23] = {{8{cinstr[11]}}, cinstr[11]};
					expand[17:13] = {cinstr[10], cinstr[4:3], 2'd2};
				end
				expand[22:18] = rpMid;
				expand[5:0] = opSx;
			end
		end
		default:
			expand[5:0] = opNop;	// Unassigned encoding
		endcase
	end

endmodule

//--- src/expandSelect.sv
// Picks the compressed or the wide result by size class and registers it
// One cycle of latency, output held while stall is high
`timescale 1ns/1ps

module expandSelect
(
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  iexpPkg::fetchBundle fetchIn,
	input  iexpPkg::instrWord cExpanded,
	input  iexpPkg::widePath wideOut,
	output iexpPkg::expandResult result
);
	import iexpPkg::*;

	logic isCompressed;
	expandResult nextResult;

	assign isCompressed = ~fetchIn.window[7];

	always_comb
	begin
		nextResult.valid = fetchIn.valid;
		nextResult.pc = fetchIn.pc;
		nextResult.compressed = isCompressed;
		if (isCompressed)
		begin
			nextResult.instr = cExpanded;
			nextResult.length = 3'd2;
			nextResult.illegal = 1'b0;
		end
		else
		begin
			nextResult.instr = wideOut.instr;
			nextResult.length = (fetchIn.window[7:6] == sizeWide48) ? 3'd6 : 3'd4;
			nextResult.illegal = fetchIn.valid & wideOut.illegal;	// Only flagged on a real bundle
		end
	end

	// ====================
	// Output register
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			result.valid <= 1'b0;
			result.illegal <= 1'b0;
		end
		else if (!stall)
			result <= nextResult;	// Idle cycle drops valid here
	end

endmodule

//--- src/iexpPkg.sv
// Shared opcodes, register numbers and bundle types for the expansion stage
// Modules import this inside their body and use scoped names in port lists
package iexpPkg;

	// ====================
	// Major opcodes of the canonical form
	localparam logic [5:0] opBrk  = 6'h00;
	localparam logic [5:0] opR2   = 6'h02;
	localparam logic [5:0] opAddi = 6'h04;
	localparam logic [5:0] opAndi = 6'h08;
	localparam logic [5:0] opOri  = 6'h09;
	localparam logic [5:0] opJal  = 6'h18;
	localparam logic [5:0] opLx   = 6'h20;
	localparam logic [5:0] opRet  = 6'h29;
	localparam logic [5:0] opSx   = 6'h30;
	localparam logic [5:0] opBcc  = 6'h38;
	localparam logic [5:0] opNop  = 6'h3D;

	// R2 function codes, bits 31:26
	localparam logic [5:0] fnAdd    = 6'h04;
	localparam logic [5:0] fnSub    = 6'h05;
	localparam logic [5:0] fnAnd    = 6'h08;
	localparam logic [5:0] fnOr     = 6'h09;
	localparam logic [5:0] fnXor    = 6'h0A;
	localparam logic [5:0] fnShiftI = 6'h0F;	// Shift by immediate 0 to 31
	localparam logic [5:0] fnMov    = 6'h22;

	localparam logic [4:0] regSp   = 5'd31;
	localparam logic [4:0] regFp   = 5'd30;
	localparam logic [4:0] regLink = 5'd29;

	localparam logic [1:0] sizeWide32 = 2'b10;
	localparam logic [1:0] sizeWide48 = 2'b11;

	// Major opcodes accepted in a 32-bit or 48-bit instruction
	localparam logic [63:0] legalMajorOps = (64'd1 << opBrk) | (64'd1 << opR2) |
		(64'd1 << opAddi) | (64'd1 << opAndi) | (64'd1 << opOri) | (64'd1 << opJal) |
		(64'd1 << opLx) | (64'd1 << opRet) | (64'd1 << opSx) | (64'd1 << opBcc) |
		(64'd1 << opNop);

	// ====================
	typedef logic [47:0] instrWord;
	typedef logic [7:0][4:0] compressedMap;

	// Entry 0 is the rightmost element
	localparam compressedMap cRegMap = {5'd20, 5'd19, 5'd18, 5'd12, 5'd11, 5'd4, 5'd3, 5'd1};

	typedef struct packed {
		logic valid;
		instrWord window;	// Low parcel in bits 15:0
		logic [31:0] pc;
	} fetchBundle;

	typedef struct packed {
		logic valid;
		instrWord instr;
		logic [31:0] pc;
		logic [2:0] length;	// Bytes
		logic compressed;
		logic illegal;
	} expandResult;

	typedef struct packed {
		instrWord instr;
		logic illegal;
	} widePath;

endpackage

//--- src/iexpandTop.sv
// Top level of the instruction-expansion stage
// Takes one fetch window per cycle, returns its canonical form a cycle later
`timescale 1ns/1ps

module iexpandTop
(
	input  logic clk,
	input  logic rstN,
	input  logic stall,
	input  iexpPkg::fetchBundle fetchIn,
	output iexpPkg::expandResult result
);
	import iexpPkg::*;

	instrWord cExpanded;
	widePath wideOut;

	compressedExpander compressedExpander_inst
	(
		.cinstr(fetchIn.window[15:0]),	// Low parcel only
		.expand(cExpanded)
	);

	wideFormatter wideFormatter_inst
	(
		.window(fetchIn.window),
		.wideOut(wideOut)
	);

	expandSelect expandSelect_inst
	(
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.fetchIn(fetchIn),
		.cExpanded(cExpanded),
		.wideOut(wideOut),
		.result(result)
	);

endmodule

//--- src/wideFormatter.sv
// Legality check and formatting of 32-bit and 48-bit instructions
// Combinational, feeds the wide input of the selector
`timescale 1ns/1ps

module wideFormatter
(
	input  iexpPkg::instrWord window,
	output iexpPkg::widePath wideOut
);
	import iexpPkg::*;

	logic [5:0] majorOp;
	logic is32;
	logic opLegal;

	assign majorOp = window[5:0];
	assign is32 = (window[7:6] == sizeWide32);
	assign opLegal = legalMajorOps[majorOp];

	// 48-bit windows pass through whole
	always_comb
	begin
		wideOut.instr = window;
		if (is32)
			wideOut.instr[47:32] = 16'h0000;	// Parcel belongs to the next instruction
		wideOut.illegal = ~opLegal;
	end

endmodule
